//--- flist.f
src/emesh_pkg.sv
src/mio_map_pkg.sv
src/req_stage.sv
src/rx_router.sv
src/pkt_arbiter.sv
src/cfg_regs.sv
src/mio_switchboard.sv
verif/tb_mio_switchboard.sv

//--- Bender.yml
package:
  name: mio_switchboard

sources:
  - src/emesh_pkg.sv
  - src/mio_map_pkg.sv
  - src/req_stage.sv
  - src/rx_router.sv
  - src/pkt_arbiter.sv
  - src/cfg_regs.sv
  - src/mio_switchboard.sv
  - target: test
    files:
      - verif/tb_mio_switchboard.sv

//--- verif/tb_mio_switchboard.sv
// Self-checking testbench for the switchboard with reference model, LFSR and watchdog
`default_nettype none

module tb_mio_switchboard import emesh_pkg::*, mio_map_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   //##########################################################################
   // DUT signals, channel 0 is link tx, 1 host rr, 2 mem wr and 3 mem rd
   //##########################################################################

   localparam int reset_cycles = 16;
   localparam int total_pkts = 20 + 9 + 20 + 10 + 400; // Packets over all tests

   logic    sys_clk = 1'b0;
   logic    rst_n = 1'b0;
   logic    host_wr_access = 1'b0, host_rd_access = 1'b0;
   logic    link_rx_access = 1'b0, mem_rr_access = 1'b0;
   packet_t host_wr_packet = '0, host_rd_packet = '0;
   packet_t link_rx_packet = '0, mem_rr_packet = '0;
   logic    host_rr_wait = 1'b0, link_tx_wait = 1'b0;
   logic    mem_wr_wait = 1'b0, mem_rd_wait = 1'b0;
   logic    host_wr_wait, host_rd_wait, link_rx_wait, mem_rr_wait;
   logic    host_rr_access, link_tx_access, mem_wr_access, mem_rd_access;
   packet_t host_rr_packet, link_tx_packet, mem_packet;

   packet_t       stim_q [4][$];              // Per source wr, rd, link rx and mem rr
   packet_t       exp_q [16][$];              // Index channel*4 + source
   packet_t       got_q [4][$];               // Per output channel
   logic [dw-1:0] model_regs [num_cfg_regs];  // Reference register file
   logic [31:0]   lfsr_q = 32'h3bd7d0d3;
   bit            rnd_idle = 1'b0;            // Random gaps on inputs
   bit            rnd_wait = 1'b0;            // Random output waits
   int            errors = 0;
   int            checks = 0;
   int            tests = 0;
   int            err_mark = 0;

   always #5 sys_clk = ~sys_clk;              // 10 ns period

   mio_switchboard mio_switchboard_inst (.*);

   //##########################################################################
   // Helpers
   //##########################################################################

   // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
         r = {r[30:0], lfsr_q[0]};
      end
      return r;
   endfunction

   task automatic check_val(input logic [pw-1:0] got, input logic [pw-1:0] exp,
                            input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t ns: %s got %h expected %h", $time, msg, got, exp);
      end
   endtask

   // Access outputs and the waits that stay low while idle
   function automatic logic [pw-1:0] idle_flags();
      return pw'({host_rr_access, link_tx_access, mem_wr_access, mem_rd_access,
                  host_wr_wait, host_rd_wait, link_rx_wait, mem_rr_wait});
   endfunction

   // Source from the srcaddr tag where nibble 8 marks a register response
   function automatic int src_of(input packet_t p);
      return (p.srcaddr[31:28] == 4'h8) ? 1 : int'(p.srcaddr[29:28]);
   endfunction

   // Expected channel and packet from the routing and response rules
   function automatic void ref_route(input int src, input packet_t p, output int ch,
                                     output packet_t q, output bit has);
      logic [cfg_idx_w-1:0] idx;
      logic                 grp_ok;
      idx = p.dstaddr[3:2];
      grp_ok = p.dstaddr[19:16] == egroup_cfg;
      has = 1'b1;
      q = p;
      ch = 0;
      if (src <= 1 && p.dstaddr[31:20] == chip_id) begin
         ch = 1;
         if (p.write) begin
            has = 1'b0;                       // Writes answer nothing
            if (grp_ok) model_regs[idx] = p.data;
         end else begin
            q.write = 1'b1;
            q.dstaddr = p.srcaddr;
            q.srcaddr = p.dstaddr;
            q.data = grp_ok ? model_regs[idx] : '0;
         end
      end else if (src == 2) begin
         if (p.dstaddr[31:20] == chip_id && p.dstaddr[19:16] == egroup_rr) ch = 1;
         else ch = p.write ? 2 : 3;
      end
   endfunction

   task automatic queue_pkt(input int src, input packet_t p);
      int      ch;
      packet_t q;
      bit      has;
      ref_route(src, p, ch, q, has);
      stim_q[src].push_back(p);
      if (has) exp_q[ch*4 + src_of(q)].push_back(q);
   endtask

   // Random packet with the source tag in srcaddr[31:28]
   function automatic packet_t rand_pkt(input int src, input logic [31:0] dst);
      packet_t p;
      p.write = 1'(rand_bits(1));
      p.datamode = 2'(rand_bits(2));
      p.ctrlmode = cmw'(rand_bits(cmw));
      p.dstaddr = dst;
      p.data = rand_bits(32);
      p.srcaddr = {src[3:0], 28'(rand_bits(28))};
      return p;
   endfunction

   function automatic logic [31:0] far_addr();
      logic [31:0] a;
      a = rand_bits(32);
      if (a[31:20] == chip_id) a[31] = ~a[31]; // Keep off this chip
      return a;
   endfunction

   task automatic set_port(input int src, input logic a, input packet_t p);
      case (src)
         0: begin
            host_wr_access = a;
            host_wr_packet = p;
         end
         1: begin
            host_rd_access = a;
            host_rd_packet = p;
         end
         2: begin
            link_rx_access = a;
            link_rx_packet = p;
         end
         default: begin
            mem_rr_access = a;
            mem_rr_packet = p;
         end
      endcase
   endtask

   function automatic logic get_wait(input int src);
      case (src)
         0: return host_wr_wait;
         1: return host_rd_wait;
         2: return link_rx_wait;
         default: return mem_rr_wait;
      endcase
   endfunction

   // Offers queued packets and holds each until accepted
   task automatic drive_loop(input int src);
      bit acc;
      forever begin
         @(posedge sys_clk);
         #1;
         if (stim_q[src].size() > 0 && (!rnd_idle || rand_bits(2) != 0)) begin
            set_port(src, 1'b1, stim_q[src][0]);
            do begin
               @(negedge sys_clk);
               acc = !get_wait(src);
               if (!acc) @(posedge sys_clk);
            end while (!acc);
            void'(stim_q[src].pop_front());   // Moves on the coming edge
         end else begin
            set_port(src, 1'b0, '0);
         end
      end
   endtask

   function automatic int pending();
      int n;
      n = 0;
      for (int i = 0; i < 4; i++) n += stim_q[i].size() + got_q[i].size();
      for (int i = 0; i < 16; i++) n += exp_q[i].size();
      return n;
   endfunction

   task automatic finish_test(input string name);
      do @(negedge sys_clk); while (pending() > 0);
      repeat (3) @(negedge sys_clk);          // Let held entries settle
      tests++;
      $display("test %-24s %s (%0d errors)", name,
               (errors == err_mark) ? "ok" : "failed", errors - err_mark);
      err_mark = errors;
   endtask

   //##########################################################################
   // Output waits, sinks and compare
   //##########################################################################

   always @(posedge sys_clk) begin
      #1;
      link_tx_wait <= rnd_wait & 1'(rand_bits(1));
      host_rr_wait <= rnd_wait & 1'(rand_bits(1));
      mem_wr_wait <= rnd_wait & 1'(rand_bits(1));
      mem_rd_wait <= rnd_wait & 1'(rand_bits(1));
   end

   always @(negedge sys_clk) begin
      if (link_tx_access && !link_tx_wait) got_q[0].push_back(link_tx_packet);
      if (host_rr_access && !host_rr_wait) got_q[1].push_back(host_rr_packet);
      if (mem_wr_access && !mem_wr_wait) got_q[2].push_back(mem_packet);
      if (mem_rd_access && !mem_rd_wait) got_q[3].push_back(mem_packet);
   end

   always @(posedge sys_clk) begin
      packet_t g;
      int      k;
      for (int ch = 0; ch < 4; ch++) begin
         while (got_q[ch].size() > 0) begin
            g = got_q[ch].pop_front();
            k = ch*4 + src_of(g);
            if (exp_q[k].size() == 0) begin
               errors++;
               $display("Unexpected packet on channel %0d at %0t ns: %h", ch, $time, g);
            end else begin
               check_val(g, exp_q[k].pop_front(), $sformatf("channel %0d", ch));
            end
         end
      end
   end

   // Watchdog
   initial begin
      repeat (reset_cycles + 40*total_pkts) @(posedge sys_clk);
      $display("Timeout: the run did not finish in time, %0d items pending", pending());
      $display("FAIL: see errors above");
      $finish;
   end

   //##########################################################################
   // Test sequence
   //##########################################################################

   initial begin
      packet_t p;
      for (int i = 0; i < num_cfg_regs; i++) model_regs[i] = '0;
      fork
         drive_loop(0);
         drive_loop(1);
         drive_loop(2);
         drive_loop(3);
      join_none
      // 1. Reset state once the first edge has applied it
      @(posedge sys_clk);
      repeat (reset_cycles - 1) begin
         @(negedge sys_clk);
         check_val(idle_flags(), '0, "reset");
      end
      @(posedge sys_clk);
      #1 rst_n = 1'b1;
      @(negedge sys_clk);
      check_val(idle_flags(), '0, "after reset");
      finish_test("reset");
      // 2. Host requests off chip go to the link
      for (int i = 0; i < 10; i++) begin
         queue_pkt(0, rand_pkt(0, far_addr()));
         queue_pkt(1, rand_pkt(1, far_addr()));
      end
      finish_test("host to link");
      // 3. Register writes then reads
      for (int i = 0; i < num_cfg_regs; i++) begin
         p = rand_pkt(0, {chip_id, egroup_cfg, 12'h0, 2'(i), 2'b00});
         p.write = 1'b1;
         queue_pkt(0, p);
      end
      finish_test("register writes");
      for (int i = 0; i < num_cfg_regs; i++) begin
         p = rand_pkt(1, {chip_id, egroup_cfg, 12'h0, 2'(i), 2'b00});
         p.write = 1'b0;
         queue_pkt(1, p);
      end
      p = rand_pkt(1, {chip_id, 4'h5, 16'h0004});
      p.write = 1'b0;
      queue_pkt(1, p);                        // Other group reads zero
      finish_test("register reads");
      // 4. Link receive routing
      for (int i = 0; i < 20; i++) begin
         if (i % 3 == 0) queue_pkt(2, rand_pkt(2, {chip_id, egroup_rr, 16'(rand_bits(16))}));
         else queue_pkt(2, rand_pkt(2, rand_bits(32)));
      end
      finish_test("link receive");
      // 5. Memory responses
      for (int i = 0; i < 10; i++) queue_pkt(3, rand_pkt(3, rand_bits(32)));
      finish_test("memory response");
      // 6. Random traffic with back-pressure
      rnd_idle = 1'b1;
      rnd_wait = 1'b1;
      for (int i = 0; i < 100; i++) begin
         queue_pkt(0, rand_pkt(0, far_addr()));
         if (rand_bits(2) == 0) begin
            p = rand_pkt(1, {chip_id, rand_bits(1) ? egroup_cfg : 4'h3, 10'h0,
                             4'(rand_bits(4)), 2'b00});
            p.write = 1'b0;
            queue_pkt(1, p);
         end else begin
            queue_pkt(1, rand_pkt(1, far_addr()));
         end
         if (rand_bits(2) == 0) queue_pkt(2, rand_pkt(2, {chip_id, egroup_rr, 16'h0}));
         else queue_pkt(2, rand_pkt(2, rand_bits(32)));
         queue_pkt(3, rand_pkt(3, rand_bits(32)));
      end
      finish_test("random back-pressure");
      rnd_wait = 1'b0;
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src/mio_switchboard.sv
// Packet switchboard between host, serial link and memory ports
`default_nettype none

module mio_switchboard import emesh_pkg::*; (
   input  logic    sys_clk,                   // System clock
   input  logic    rst_n,                     // Sync reset, active low
   // Host write requests
   input  logic    host_wr_access,
   input  packet_t host_wr_packet,
   output logic    host_wr_wait,
   // Host read requests
   input  logic    host_rd_access,
   input  packet_t host_rd_packet,
   output logic    host_rd_wait,
   // Host read responses
   output logic    host_rr_access,
   output packet_t host_rr_packet,
   input  logic    host_rr_wait,
   // Link transmit
   output logic    link_tx_access,
   output packet_t link_tx_packet,
   input  logic    link_tx_wait,
   // Link receive
   input  logic    link_rx_access,
   input  packet_t link_rx_packet,
   output logic    link_rx_wait,
   // Memory requests, shared packet bus
   output logic    mem_wr_access,
   output logic    mem_rd_access,
   output packet_t mem_packet,
   input  logic    mem_wr_wait,
   input  logic    mem_rd_wait,
   // Memory read responses
   input  logic    mem_rr_access,
   input  packet_t mem_rr_packet,
   output logic    mem_rr_wait
);

   //##########################################################################
   // Internal wiring, index 0 host write and 1 host read
   //##########################################################################

   logic    [1:0] host_access;
   packet_t [1:0] host_packet;
   logic    [1:0] host_wait;
   logic    [1:0] stg_reg_access;             // Stage to register arbiter
   logic    [1:0] stg_link_access;            // Stage to link arbiter
   packet_t [1:0] stg_packet;
   logic    [1:0] stg_reg_wait;
   logic    [1:0] stg_link_wait;
   logic    [2:0] tx_wait;                    // Link arbiter input waits
   logic          cfg_req_access;
   packet_t       cfg_req_packet;
   logic          cfg_req_wait;
   logic          cfg_rsp_access;
   packet_t       cfg_rsp_packet;
   logic          cfg_rsp_wait;
   logic          rx_rr_access;               // Link packet bound for host
   logic          rx_rr_wait;
   packet_t       rx_packet;
   logic    [1:0] rr_wait;                    // Host response arbiter waits

   assign host_access = {host_rd_access, host_wr_access};
   assign host_packet = {host_rd_packet, host_wr_packet};
   assign host_wr_wait = host_wait[0];
   assign host_rd_wait = host_wait[1];
   assign stg_link_wait = tx_wait[1:0];
   assign mem_rr_wait = tx_wait[2];
   assign rx_rr_wait = rr_wait[0];
   assign cfg_rsp_wait = rr_wait[1];
   assign mem_packet = rx_packet;

   //##########################################################################
   // Host request stages
   //##########################################################################

   for (genvar g = 0; g < 2; g++) begin : gen_req
      req_stage req_stage_inst (
         .sys_clk     (sys_clk),
         .rst_n       (rst_n),
         .in_access   (host_access[g]),
         .in_packet   (host_packet[g]),
         .in_wait     (host_wait[g]),
         .reg_access  (stg_reg_access[g]),
         .link_access (stg_link_access[g]),
         .out_packet  (stg_packet[g]),
         .reg_wait    (stg_reg_wait[g]),
         .link_wait   (stg_link_wait[g])
      );
   end

   // Link transmit: host write, host read, then memory response
   pkt_arbiter #(.n(3)) link_tx_arb (
      .in_access  ({mem_rr_access, stg_link_access}),
      .in_packet  ({mem_rr_packet, stg_packet}),
      .in_wait    (tx_wait),
      .out_access (link_tx_access),
      .out_packet (link_tx_packet),
      .out_wait   (link_tx_wait)
   );

   // Register block requests, write stage first
   pkt_arbiter #(.n(2)) cfg_arb (
      .in_access  (stg_reg_access),
      .in_packet  (stg_packet),
      .in_wait    (stg_reg_wait),
      .out_access (cfg_req_access),
      .out_packet (cfg_req_packet),
      .out_wait   (cfg_req_wait)
   );

   cfg_regs cfg_regs_inst (
      .sys_clk    (sys_clk),
      .rst_n      (rst_n),
      .req_access (cfg_req_access),
      .req_packet (cfg_req_packet),
      .req_wait   (cfg_req_wait),
      .rsp_access (cfg_rsp_access),
      .rsp_packet (cfg_rsp_packet),
      .rsp_wait   (cfg_rsp_wait)
   );

   //##########################################################################
   // Link receive and host responses
   //##########################################################################

   rx_router rx_router_inst (
      .sys_clk       (sys_clk),
      .rst_n         (rst_n),
      .rx_access     (link_rx_access),
      .rx_packet     (link_rx_packet),
      .rx_wait       (link_rx_wait),
      .rr_access     (rx_rr_access),
      .mem_wr_access (mem_wr_access),
      .mem_rd_access (mem_rd_access),
      .out_packet    (rx_packet),
      .rr_wait       (rx_rr_wait),
      .mem_wr_wait   (mem_wr_wait),
      .mem_rd_wait   (mem_rd_wait)
   );

   // Link responses ahead of register responses
   pkt_arbiter #(.n(2)) rr_arb (
      .in_access  ({cfg_rsp_access, rx_rr_access}),
      .in_packet  ({cfg_rsp_packet, rx_packet}),
      .in_wait    (rr_wait),
      .out_access (host_rr_access),
      .out_packet (host_rr_packet),
      .out_wait   (host_rr_wait)
   );

endmodule

`default_nettype wire

//--- src/cfg_regs.sv
// Configuration register block, stores writes and answers reads with packets
`default_nettype none

module cfg_regs import emesh_pkg::*, mio_map_pkg::*; (
   input  logic    sys_clk,                   // System clock
   input  logic    rst_n,                     // Sync reset, active low
   // Requests from the host stages
   input  logic    req_access,
   input  packet_t req_packet,
   output logic    req_wait,
   // Read responses toward the host
   output logic    rsp_access,
   output packet_t rsp_packet,
   input  logic    rsp_wait
);

   logic [dw-1:0]        regs [num_cfg_regs]; // Register file
   logic [cfg_idx_w-1:0] idx;                 // Word index from dstaddr
   logic                 cfg_hit;             // Group selects register block
   logic                 req_fire;
   logic                 rsp_full;            // Response held, not yet taken
   packet_t              rsp_q;

   assign idx = req_packet.dstaddr[cfg_idx_w+1:2]; // Word aligned
   assign cfg_hit = req_packet.dstaddr[19:16] == egroup_cfg;

   // A pending response blocks the next request unless it leaves now
   assign req_wait = rsp_full & rsp_wait;
   assign req_fire = req_access & ~req_wait;

   assign rsp_access = rsp_full;
   assign rsp_packet = rsp_q;

   //##########################################################################
   // Register writes
   //##########################################################################

   always_ff @(posedge sys_clk) begin
      if (!rst_n) begin
         for (int i = 0; i < num_cfg_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (req_fire && req_packet.write && cfg_hit) begin
         regs[idx] <= req_packet.data;        // Other groups dropped silently
      end
   end

   //##########################################################################
   // Read response
   //##########################################################################

   always_ff @(posedge sys_clk) begin
      if (!rst_n) begin
         rsp_full <= 1'b0;
         rsp_q <= '0;
      end else begin
         if (rsp_full && !rsp_wait) begin
            rsp_full <= 1'b0;                 // Taken by host response arbiter
         end
         if (req_fire && !req_packet.write) begin
            rsp_full <= 1'b1;                 // New read overrides the clear
            rsp_q.write <= 1'b1;              // Responses travel as writes
            rsp_q.datamode <= req_packet.datamode;
            rsp_q.ctrlmode <= req_packet.ctrlmode;
            rsp_q.dstaddr <= req_packet.srcaddr; // Back to requester
            rsp_q.data <= cfg_hit ? regs[idx] : '0;
            rsp_q.srcaddr <= req_packet.dstaddr;
         end
      end
   end

endmodule

`default_nettype wire

//--- src/pkt_arbiter.sv
// Fixed-priority packet multiplexer, lowest input index wins
`default_nettype none

module pkt_arbiter import emesh_pkg::*; #(
   parameter int n = 2                        // Number of inputs, 2 or more
) (
   input  logic    [n-1:0] in_access,
   input  packet_t [n-1:0] in_packet,
   output logic    [n-1:0] in_wait,
   output logic            out_access,
   output packet_t         out_packet,
   input  logic            out_wait
);

   logic [n-1:0] grant;                       // One-hot, or zero when idle

   // Isolate lowest set request bit
   assign grant = in_access & (~in_access + 1'b1);

   assign out_access = |in_access;

   // Losers wait, winner sees downstream wait, idle inputs see nothing
   assign in_wait = (in_access & ~grant) | (grant & {n{out_wait}});

   always_comb begin
      out_packet = '0;
      for (int i = 0; i < n; i++) begin
         if (grant[i]) begin
            out_packet = in_packet[i];        // At most one grant set
         end
      end
   end

endmodule

`default_nettype wire

//--- src/rx_router.sv
// One-entry link receive stage that routes packets to host response or memory
`default_nettype none

module rx_router import emesh_pkg::*, mio_map_pkg::*; (
   input  logic    sys_clk,                   // System clock
   input  logic    rst_n,                     // Sync reset, active low
   // Link receive
   input  logic    rx_access,
   input  packet_t rx_packet,
   output logic    rx_wait,
   // Destinations, shared packet bus
   output logic    rr_access,                 // Host read response
   output logic    mem_wr_access,             // Memory write
   output logic    mem_rd_access,             // Memory read
   output packet_t out_packet,
   input  logic    rr_wait,
   input  logic    mem_wr_wait,
   input  logic    mem_rd_wait
);

   //##########################################################################
   // Classify on entry, one-hot {rd, wr, rr}
   //##########################################################################

   logic       is_rr;                         // Addressed back to the host
   logic [2:0] dst_d;
   logic [2:0] dst_q;
   logic       full;
   logic       sel_wait;                      // Wait of the chosen destination
   logic       rx_fire;
   packet_t    pkt_q;

   assign is_rr = (rx_packet.dstaddr[31:20] == chip_id) &&
                  (rx_packet.dstaddr[19:16] == egroup_rr);

   assign dst_d = is_rr           ? 3'b001 :  // Response wins over write flag
                  rx_packet.write ? 3'b010 :
                                    3'b100;

   assign sel_wait = |(dst_q & {mem_rd_wait, mem_wr_wait, rr_wait});
   assign rx_wait = full & sel_wait;          // Back-pressure to link
   assign rx_fire = rx_access & ~rx_wait;

   assign rr_access = full & dst_q[0];
   assign mem_wr_access = full & dst_q[1];
   assign mem_rd_access = full & dst_q[2];
   assign out_packet = pkt_q;

   //##########################################################################
   // Holding register
   //##########################################################################

   always_ff @(posedge sys_clk) begin
      if (!rst_n) begin
         full <= 1'b0;
         dst_q <= '0;
         pkt_q <= '0;
      end else if (rx_fire) begin
         full <= 1'b1;                        // Back-to-back without bubble
         dst_q <= dst_d;
         pkt_q <= rx_packet;
      end else if (full && !sel_wait) begin
         full <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- src/req_stage.sv
// One-entry host request stage that steers a request to the registers or the link
`default_nettype none

module req_stage import emesh_pkg::*, mio_map_pkg::*; (
   input  logic    sys_clk,                   // System clock
   input  logic    rst_n,                     // Sync reset, active low
   // Host side
   input  logic    in_access,
   input  packet_t in_packet,
   output logic    in_wait,
   // Targets, one packet bus for both
   output logic    reg_access,                // To register block arbiter
   output logic    link_access,               // To link transmit arbiter
   output packet_t out_packet,
   input  logic    reg_wait,
   input  logic    link_wait
);

   logic    full;                             // Entry holds a request
   logic    is_reg;                           // Held request targets registers
   logic    sel_wait;                         // Wait of the chosen target
   logic    in_fire;                          // Request accepted this edge
   logic    reg_match;                        // Incoming request hits chip id
   packet_t pkt_q;

   assign reg_match = in_packet.dstaddr[31:20] == chip_id; // Chip id decode on entry
   assign sel_wait = is_reg ? reg_wait : link_wait;
   assign in_wait = full & sel_wait;          // Only blocks when stuck
   assign in_fire = in_access & ~in_wait;

   assign reg_access = full & is_reg;
   assign link_access = full & ~is_reg;
   assign out_packet = pkt_q;

   always_ff @(posedge sys_clk) begin
      if (!rst_n) begin
         full <= 1'b0;
         is_reg <= 1'b0;
         pkt_q <= '0;
      end else if (in_fire) begin
         full <= 1'b1;                        // Refill, possibly as old one leaves
         is_reg <= reg_match;
         pkt_q <= in_packet;
      end else if (full && !sel_wait) begin
         full <= 1'b0;                        // Drained, nothing new
      end
   end

endmodule

`default_nettype wire

//--- src/mio_map_pkg.sv
// Address map of the MIO chip: chip id, address groups and register file size
`default_nettype none

package mio_map_pkg;

   //##########################################################################
   // dstaddr decode, bits 31..20 chip and 19..16 group
   //##########################################################################

   localparam logic [11:0] chip_id    = 12'h810; // This chip
   localparam logic [3:0]  egroup_cfg = 4'h0;    // Register block group
   localparam logic [3:0]  egroup_rr  = 4'hD;    // Host read response group

   // Register file
   localparam int num_cfg_regs = 4;           // 32-bit registers
   localparam int cfg_idx_w    = 2;           // Index from dstaddr[3:2]

endpackage

`default_nettype wire

//--- src/emesh_pkg.sv
// Emesh packet format shared by every port of the switchboard
`default_nettype none

package emesh_pkg;

   //##########################################################################
   // Widths
   //##########################################################################

   localparam int aw = 32;                    // Address width
   localparam int dw = 32;                    // Data width
   localparam int pw = 2*aw + 40;             // Packet width, 104 bits
   localparam int dmw = 2;                    // Datamode width
   localparam int cmw = pw - 2*aw - dw - dmw - 1; // Ctrlmode width, what is left

   //##########################################################################
   // Packet layout, MSB first
   //##########################################################################

   typedef struct packed {
      logic           write;                  // 1 = write, 0 = read
      logic [dmw-1:0] datamode;               // Transfer size code
      logic [cmw-1:0] ctrlmode;               // Control bits, passed through
      logic [aw-1:0]  dstaddr;                // Target address
      logic [dw-1:0]  data;                   // Write data or read result
      logic [aw-1:0]  srcaddr;                // Return address for reads
   } packet_t;

endpackage

`default_nettype wire
